//--- sim.f
mac_pkg.sv
wb_map_pkg.sv
mul_add_unit.sv
mac_sequencer.sv
mac_wb_regs.sv
mac_top.sv
tb_clock_gen.sv
tb_mac_top.sv

//--- run_sim.sh
#!/bin/bash
# build and run the MAC engine testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --timescale 1ns/1ns --top-module tb_mac_top \
    -Mdir obj_dir -o tb_mac_top -f sim.f || { echo "build failed"; exit 1; }

./obj_dir/tb_mac_top > sim.log 2>&1
cat sim.log

grep -qF '*** FAILED ***' sim.log && exit 1
grep -qF '*** PASSED ***' sim.log || exit 1
exit 0

//--- tb_mac_top.sv
`timescale 1ns/1ns

module tb_mac_top;

    // about 200 operations of up to 40 cycles each, with margin
    localparam int num_ops       = 200;
    localparam int cycles_per_op = 40;
    localparam int max_cycles    = num_ops * cycles_per_op * 5 / 2;

    logic                               clk;
    logic                               reset;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    logic [wb_map_pkg::ADDR_WIDTH-1:0]  wb_adr;
    logic [wb_map_pkg::DATA_WIDTH-1:0]  wb_dat_w;
    logic [wb_map_pkg::DATA_WIDTH-1:0]  wb_dat_r;
    logic                               wb_ack;

    int                                 seed = 32'h6f54;
    int                                 cycles = 0;
    int                                 waits;
    int                                 len;
    logic [31:0]                        rdata;
    logic signed [mac_pkg::A_WIDTH-1:0] a_val;
    logic signed [mac_pkg::B_WIDTH-1:0] b_val;
    logic signed [mac_pkg::C_WIDTH-1:0] c_val;
    logic signed [mac_pkg::P_WIDTH-1:0] model;
    mac_pkg::op_t                       first_load;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    mac_top uut (.*);

    // --------------------------------------------------
    // reference model and word helpers
    // --------------------------------------------------
    function automatic logic signed [47:0] apply_op(mac_pkg::op_t op, logic signed [47:0] acc,
            logic signed [47:0] a_in, logic signed [47:0] b_in, logic signed [47:0] c_in);
        logic signed [47:0] prod;
        prod = a_in * b_in;
        case (op)
            mac_pkg::op_clear:    return c_in;
            mac_pkg::op_load_add: return c_in + prod;
            mac_pkg::op_load_sub: return c_in - prod;
            mac_pkg::op_acc_add:  return acc + prod;
            mac_pkg::op_acc_sub:  return acc - prod;
            default:              return acc;
        endcase
    endfunction

    function automatic logic [31:0] lo_word(logic signed [47:0] v);
        return v[31:0];
    endfunction

    // upper word of a value sign-extended across two words
    function automatic logic [31:0] hi_word(logic signed [47:0] v);
        logic signed [63:0] ext;
        ext = v;
        return ext[63:32];
    endfunction

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] observed);
        assert (observed === expected) else begin
            $display("FAILED at %0t ns: %s expected %h observed %h",
                     $time, name, expected, observed);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // --------------------------------------------------
    // bus driver
    // --------------------------------------------------
    task automatic bus_cycle(logic we, wb_map_pkg::reg_addr_t adr, logic [31:0] wdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waits    = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waits++;
            @(negedge clk);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic randomize_operands();
        a_val = $random(seed);
        b_val = $random(seed);
        c_val = {$random(seed), $random(seed)};
    endtask

    task automatic write_operands();
        bus_cycle(1'b1, wb_map_pkg::reg_a, lo_word(a_val));
        bus_cycle(1'b1, wb_map_pkg::reg_b, lo_word(b_val));
        bus_cycle(1'b1, wb_map_pkg::reg_c_lo, lo_word(c_val));
        bus_cycle(1'b1, wb_map_pkg::reg_c_hi, hi_word(c_val));
    endtask

    task automatic run_cmd(mac_pkg::op_t cmd);
        bus_cycle(1'b1, wb_map_pkg::reg_cmd, 32'(cmd));
        model = apply_op(cmd, model, a_val, b_val, c_val);
    endtask

    // poll until idle, then compare both result words
    task automatic check_result();
        rdata = 32'd1;
        while (rdata[0]) begin
            bus_cycle(1'b0, wb_map_pkg::reg_status, 32'd0);
        end
        bus_cycle(1'b0, wb_map_pkg::reg_p_lo, 32'd0);
        check_word("p_lo", lo_word(model), rdata);
        bus_cycle(1'b0, wb_map_pkg::reg_p_hi, 32'd0);
        check_word("p_hi", hi_word(model), rdata);
    endtask

    always @(posedge clk) begin
        cycles++;
        assert (cycles < max_cycles) else begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        model    = '0;
        wait (!reset);
        repeat (4) begin
            @(negedge clk);
            check_word("wb_ack", 32'd0, {31'd0, wb_ack});
        end
        bus_cycle(1'b0, wb_map_pkg::reg_p_lo, 32'd0);
        check_word("p_lo", 32'd0, rdata);
        bus_cycle(1'b0, wb_map_pkg::reg_p_hi, 32'd0);
        check_word("p_hi", 32'd0, rdata);
        bus_cycle(1'b0, wb_map_pkg::reg_status, 32'd0);
        check_word("status", 32'd0, rdata);

        // single loads
        repeat (40) begin
            randomize_operands();
            write_operands();
            run_cmd(($random(seed) & 1) ? mac_pkg::op_load_sub : mac_pkg::op_load_add);
            check_result();
        end

        // accumulate chains, commands back to back
        repeat (20) begin
            randomize_operands();
            write_operands();
            len = ($random(seed) & 7) + 1;
            repeat (len) begin
                if (($random(seed) & 3) == 0) begin
                    a_val = $random(seed);
                    bus_cycle(1'b1, wb_map_pkg::reg_a, lo_word(a_val));
                end
                run_cmd(($random(seed) & 1) ? mac_pkg::op_acc_sub : mac_pkg::op_acc_add);
            end
            check_result();
        end

        // load right behind a load has to wait for ready
        repeat (10) begin
            randomize_operands();
            write_operands();
            first_load = ($random(seed) & 1) ? mac_pkg::op_load_sub : mac_pkg::op_load_add;
            run_cmd(first_load);
            // opposite sign so the second result differs from the first
            run_cmd((first_load == mac_pkg::op_load_sub) ? mac_pkg::op_load_add
                                                         : mac_pkg::op_load_sub);
            assert (waits > 1) else begin
                $display("second load command was acknowledged without waiting for ready");
                $display("*** FAILED ***");
                $fatal(1, "no back-pressure");
            end
            check_result();
        end

        // clear, then accumulate from C
        repeat (10) begin
            randomize_operands();
            write_operands();
            run_cmd(mac_pkg::op_clear);
            check_result();
            randomize_operands();
            bus_cycle(1'b1, wb_map_pkg::reg_a, lo_word(a_val));
            bus_cycle(1'b1, wb_map_pkg::reg_b, lo_word(b_val));
            run_cmd(($random(seed) & 1) ? mac_pkg::op_acc_sub : mac_pkg::op_acc_add);
            check_result();
        end

        // operand readback
        repeat (10) begin
            randomize_operands();
            write_operands();
            bus_cycle(1'b0, wb_map_pkg::reg_a, 32'd0);
            check_word("reg_a", lo_word(a_val), rdata);
            bus_cycle(1'b0, wb_map_pkg::reg_b, 32'd0);
            check_word("reg_b", lo_word(b_val), rdata);
            bus_cycle(1'b0, wb_map_pkg::reg_c_lo, 32'd0);
            check_word("reg_c_lo", lo_word(c_val), rdata);
            bus_cycle(1'b0, wb_map_pkg::reg_c_hi, 32'd0);
            check_word("reg_c_hi", hi_word(c_val), rdata);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- mac_top.sv
`timescale 1ns/1ns

module mac_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [wb_map_pkg::ADDR_WIDTH-1:0]   wb_adr,
    input  logic [wb_map_pkg::DATA_WIDTH-1:0]   wb_dat_w,
    output logic [wb_map_pkg::DATA_WIDTH-1:0]   wb_dat_r,
    output logic                                wb_ack
);

    logic signed [mac_pkg::A_WIDTH-1:0] a;
    logic signed [mac_pkg::B_WIDTH-1:0] b;
    logic signed [mac_pkg::C_WIDTH-1:0] c;
    logic signed [mac_pkg::P_WIDTH-1:0] p;
    mac_pkg::op_t                       opcode;
    logic                               issue;
    logic                               busy;
    logic                               ready;
    logic                               cke_ctrl;
    logic                               cke_alumode;
    logic                               cke_a0;
    logic                               cke_a1;
    logic                               cke_b0;
    logic                               cke_b1;
    logic                               cke_c;
    logic                               cke_m;
    logic                               cke_p;
    logic                               op_load;
    logic                               alu_sub;
    logic                               clear_operands;

    // host side register file
    mac_wb_regs #(
        .a_width(mac_pkg::A_WIDTH),
        .b_width(mac_pkg::B_WIDTH),
        .c_width(mac_pkg::C_WIDTH),
        .p_width(mac_pkg::P_WIDTH)
    ) u_regs (.*);

    mac_sequencer u_seq (.*);

    mul_add_unit #(
        .a_width(mac_pkg::A_WIDTH),
        .b_width(mac_pkg::B_WIDTH),
        .c_width(mac_pkg::C_WIDTH),
        .p_width(mac_pkg::P_WIDTH)
    ) u_mac (.*);

endmodule

//--- mac_wb_regs.sv
`timescale 1ns/1ns

module mac_wb_regs #(
    parameter int a_width = mac_pkg::A_WIDTH,
    parameter int b_width = mac_pkg::B_WIDTH,
    parameter int c_width = mac_pkg::C_WIDTH,
    parameter int p_width = mac_pkg::P_WIDTH
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [wb_map_pkg::ADDR_WIDTH-1:0]   wb_adr,
    input  logic [wb_map_pkg::DATA_WIDTH-1:0]   wb_dat_w,
    output logic [wb_map_pkg::DATA_WIDTH-1:0]   wb_dat_r,
    output logic                                wb_ack,
    input  logic signed [p_width-1:0]           p,
    input  logic                                busy,
    input  logic                                ready,
    output logic signed [a_width-1:0]           a,
    output logic signed [b_width-1:0]           b,
    output logic signed [c_width-1:0]           c,
    output logic                                issue,
    output mac_pkg::op_t                        opcode
);

    localparam int dw = wb_map_pkg::DATA_WIDTH;

    wb_map_pkg::reg_addr_t  adr;
    logic                   held;
    logic                   req;
    logic                   cmd_write;
    logic                   ack_next;
    logic                   wr_en;
    logic signed [dw-1:0]   a_ext;
    logic signed [dw-1:0]   b_ext;
    logic signed [2*dw-1:0] c_ext;
    logic signed [2*dw-1:0] p_ext;
    logic [2*dw-1:0]        c_wr_lo;
    logic [2*dw-1:0]        c_wr_hi;
    logic [dw-1:0]          rd_data;

    assign adr       = wb_map_pkg::reg_addr_t'(wb_adr);
    assign req       = wb_cyc && wb_stb && !wb_ack && !held;
    assign cmd_write = wb_we && (adr == wb_map_pkg::reg_cmd);
    // command writes stall here until the pipeline can take them
    assign ack_next  = req && (!cmd_write || ready);
    assign wr_en     = ack_next && wb_we;

    assign a_ext   = a;
    assign b_ext   = b;
    assign c_ext   = c;
    assign p_ext   = p;
    assign c_wr_lo = {c_ext[2*dw-1:dw], wb_dat_w};
    assign c_wr_hi = {wb_dat_w, c_ext[dw-1:0]};

    // --------------------------------------------------
    // bus handshake
    // --------------------------------------------------
    // held blocks a second ack until stb has dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            held   <= 1'b0;
            issue  <= 1'b0;
        end else begin
            wb_ack <= ack_next;
            held   <= (wb_ack || held) && wb_stb;
            issue  <= ack_next && cmd_write;
        end
    end

    always_comb begin
        case (adr)
            wb_map_pkg::reg_a:      rd_data = a_ext;
            wb_map_pkg::reg_b:      rd_data = b_ext;
            wb_map_pkg::reg_c_lo:   rd_data = c_ext[dw-1:0];
            wb_map_pkg::reg_c_hi:   rd_data = c_ext[2*dw-1:dw];
            wb_map_pkg::reg_status: rd_data = {{(dw-1){1'b0}}, busy};
            wb_map_pkg::reg_p_lo:   rd_data = p_ext[dw-1:0];
            wb_map_pkg::reg_p_hi:   rd_data = p_ext[2*dw-1:dw];
            default:                rd_data = '0;
        endcase
    end

    // operand and read data registers
    always_ff @(posedge clk) begin
        if (ack_next) begin
            wb_dat_r <= rd_data;
        end
        if (wr_en) begin
            case (adr)
                wb_map_pkg::reg_a:    a <= wb_dat_w[a_width-1:0];
                wb_map_pkg::reg_b:    b <= wb_dat_w[b_width-1:0];
                wb_map_pkg::reg_c_lo: c <= c_wr_lo[c_width-1:0];
                wb_map_pkg::reg_c_hi: c <= c_wr_hi[c_width-1:0];
                default: ;
            endcase
        end
        if (ack_next && cmd_write) begin
            opcode <= mac_pkg::op_t'(wb_dat_w[mac_pkg::OP_WIDTH-1:0]);
        end
    end

endmodule

//--- mac_sequencer.sv
`timescale 1ns/1ns

module mac_sequencer (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue,
    input  mac_pkg::op_t    opcode,
    output logic            cke_ctrl,
    output logic            cke_alumode,
    output logic            cke_a0,
    output logic            cke_a1,
    output logic            cke_b0,
    output logic            cke_b1,
    output logic            cke_c,
    output logic            cke_m,
    output logic            cke_p,
    output logic            op_load,
    output logic            alu_sub,
    output logic            clear_operands,
    output logic            busy,
    output logic            ready
);

    // stage 1 is the issue cycle itself, stages 2 to 4 are tracked here
    logic           v2;
    logic           v3;
    logic           v4;
    mac_pkg::op_t   op2;
    mac_pkg::op_t   op3;

    function automatic logic is_load(mac_pkg::op_t op);
        return (op == mac_pkg::op_clear) ||
               (op == mac_pkg::op_load_add) ||
               (op == mac_pkg::op_load_sub);
    endfunction

    function automatic logic is_sub(mac_pkg::op_t op);
        return (op == mac_pkg::op_load_sub) || (op == mac_pkg::op_acc_sub);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            v2 <= 1'b0;
            v3 <= 1'b0;
            v4 <= 1'b0;
        end else begin
            v2 <= issue;
            v3 <= v2;
            v4 <= v3;
        end
    end

    // opcodes only advance with a valid item
    always_ff @(posedge clk) begin
        if (issue) begin
            op2 <= opcode;
        end
        if (v2) begin
            op3 <= op2;
        end
    end

    // --------------------------------------------------
    // per-stage enables and aligned controls
    // --------------------------------------------------
    assign cke_a0         = issue;
    assign cke_b0         = issue;
    assign cke_c          = issue;
    assign clear_operands = issue && (opcode == mac_pkg::op_clear);
    assign cke_a1         = v2;
    assign cke_b1         = v2;
    assign cke_m          = v3;
    assign cke_ctrl       = v3;
    assign cke_alumode    = v3;
    assign cke_p          = v4;
    assign op_load        = v3 && is_load(op3);
    assign alu_sub        = v3 && is_sub(op3);

    assign busy = issue || v2 || v3 || v4;

    // c0 must hold until a load reaches the P stage
    assign ready = !(v2 && is_load(op2)) && !(v3 && is_load(op3));

endmodule

//--- mul_add_unit.sv
`timescale 1ns/1ns

module mul_add_unit #(
    parameter int a_width = mac_pkg::A_WIDTH,
    parameter int b_width = mac_pkg::B_WIDTH,
    parameter int c_width = mac_pkg::C_WIDTH,
    parameter int p_width = mac_pkg::P_WIDTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cke_ctrl,
    input  logic                        cke_alumode,
    input  logic                        cke_a0,
    input  logic                        cke_a1,
    input  logic                        cke_b0,
    input  logic                        cke_b1,
    input  logic                        cke_c,
    input  logic                        cke_m,
    input  logic                        cke_p,
    input  logic                        op_load,
    input  logic                        alu_sub,
    input  logic                        clear_operands,
    input  logic signed [a_width-1:0]   a,
    input  logic signed [b_width-1:0]   b,
    input  logic signed [c_width-1:0]   c,
    output logic signed [p_width-1:0]   p
);

    localparam int m_width = a_width + b_width;

    logic                       opmode_load;
    logic                       alumode_sub;
    logic signed [a_width-1:0]  a0;
    logic signed [a_width-1:0]  a1;
    logic signed [b_width-1:0]  b0;
    logic signed [b_width-1:0]  b1;
    logic signed [c_width-1:0]  c0;
    logic signed [m_width-1:0]  m0;
    logic signed [p_width-1:0]  p0;
    logic signed [p_width-1:0]  c_base;
    logic signed [p_width-1:0]  m_ext;
    logic signed [p_width-1:0]  base;

    // --------------------------------------------------
    // control registers, captured with the M stage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            opmode_load <= 1'b0;
        end else if (cke_ctrl) begin
            opmode_load <= op_load;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alumode_sub <= 1'b0;
        end else if (cke_alumode) begin
            alumode_sub <= alu_sub;
        end
    end

    // --------------------------------------------------
    // operand stages
    // --------------------------------------------------
    // zero select on the first stage makes the product vanish
    always_ff @(posedge clk) begin
        if (reset) begin
            a0 <= '0;
        end else if (cke_a0) begin
            a0 <= clear_operands ? '0 : a;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a1 <= '0;
        end else if (cke_a1) begin
            a1 <= a0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            b0 <= '0;
        end else if (cke_b0) begin
            b0 <= clear_operands ? '0 : b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            b1 <= '0;
        end else if (cke_b1) begin
            b1 <= b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            c0 <= '0;
        end else if (cke_c) begin
            c0 <= c;
        end
    end

    // --------------------------------------------------
    // multiply and accumulate
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m0 <= '0;
        end else if (cke_m) begin
            m0 <= a1 * b1;
        end
    end

    // sign extension into the accumulator width
    assign c_base = c0;
    assign m_ext  = m0;
    assign base   = opmode_load ? c_base : p0;

    always_ff @(posedge clk) begin
        if (reset) begin
            p0 <= '0;
        end else if (cke_p) begin
            p0 <= alumode_sub ? base - m_ext : base + m_ext;
        end
    end

    assign p = p0;

endmodule

//--- wb_map_pkg.sv
package wb_map_pkg;

    parameter int DATA_WIDTH = 32;
    parameter int ADDR_WIDTH = 3;

    // word addresses seen by the host
    typedef enum logic [ADDR_WIDTH-1:0] {
        reg_a      = 3'd0,
        reg_b      = 3'd1,
        reg_c_lo   = 3'd2,
        reg_c_hi   = 3'd3,
        reg_cmd    = 3'd4,
        reg_status = 3'd5,
        reg_p_lo   = 3'd6,
        reg_p_hi   = 3'd7
    } reg_addr_t;

endpackage

//--- mac_pkg.sv
package mac_pkg;

    // default datapath widths
    parameter int A_WIDTH = 18;
    parameter int B_WIDTH = 18;
    parameter int C_WIDTH = 48;
    parameter int P_WIDTH = 48;

    parameter int OP_WIDTH = 3;

    // host command opcodes
    // clear runs through the pipe as a load-add with zero operands
    typedef enum logic [OP_WIDTH-1:0] {
        op_clear    = 3'd0,
        op_load_add = 3'd1,
        op_load_sub = 3'd2,
        op_acc_add  = 3'd3,
        op_acc_sub  = 3'd4
    } op_t;

endpackage
